/* execUnit.f */
source/aluPkg.sv
source/execBus.sv
source/aluControl.sv
source/opDecode.sv
source/issueQueue.sv
source/aluExecute.sv
source/execUnit.sv
bench/execUnit_asserts.sv
bench/execUnitTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f execUnit.f --top-module execUnitTb -o simExec
./obj_dir/simExec > sim.log 2>&1
cat sim.log
if grep -q "Finished with no errors" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* bench/execUnitTb.sv */
`timescale 1ns/1ns

module execUnitTb;

  localparam int randCount  = 300;  // mixed random instructions
  localparam int mulCount   = 40;   // back-to-back multiplies
  localparam int watchLimit = (randCount + mulCount) * 40 + 1000;

  logic        clk;
  logic        arstN;
  logic        instrValid;
  logic [31:0] instr;
  logic [31:0] rs1Val;
  logic [31:0] rs2Val;
  logic        resValid;
  logic [31:0] result;
  logic        brTaken;
  logic        overflow;

  integer      seed = 32'hd3031b7a;
  int          errors;
  int          issued;
  int          idle;
  logic        lossy;              // drops expected once the queue overflows
  logic [32:0] expQ[$];            // {result, brTaken} in request order
  logic [31:0] r;
  logic [31:0] opA;
  logic [31:0] opB;

  execUnit #(.queueDepth(4)) u_dut (
    .clk(clk), .arstN(arstN), .instrValid(instrValid), .instr(instr),
    .rs1Val(rs1Val), .rs2Val(rs2Val), .resValid(resValid), .result(result),
    .brTaken(brTaken), .overflow(overflow)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic compare(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  function automatic logic [31:0] intOp(logic [2:0] f3, logic alt, logic [31:0] x,
                                        logic [31:0] y);
    logic [31:0] res;
    case (f3)
      3'd0: res = alt ? x - y : x + y;
      3'd1: res = x << y[4:0];
      3'd2: res = {31'b0, $signed(x) < $signed(y)};
      3'd3: res = {31'b0, x < y};
      3'd4: res = x ^ y;
      3'd5: begin
        if (alt) res = $signed(x) >>> y[4:0];
        else res = x >> y[4:0];
      end
      3'd6: res = x | y;
      default: res = x & y;
    endcase
    return res;
  endfunction

  // reference RV32IM model giving {result, taken}
  function automatic logic [32:0] modelExec(logic [31:0] ins, logic [31:0] a, logic [31:0] b);
    logic [2:0]  f3;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] res;
    logic        t;
    logic [63:0] sa;
    logic [63:0] sb;
    logic [63:0] ub;
    logic [63:0] prod;
    f3   = ins[14:12];
    immI = {{20{ins[31]}}, ins[31:20]};
    immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    sa   = {{32{a[31]}}, a};
    sb   = {{32{b[31]}}, b};
    ub   = {32'b0, b};
    res  = '0;
    t    = 1'b0;
    prod = '0;
    case (ins[6:0])
      7'b0000011: res = a + immI;  // load address
      7'b0100011: res = a + immS;  // store address
      7'b0110111: res = {ins[31:12], 12'b0};
      7'b1100011: begin
        case (f3)
          3'd0: t = (a == b);
          3'd1: t = (a != b);
          3'd4: t = ($signed(a) < $signed(b));
          3'd5: t = ($signed(a) >= $signed(b));
          3'd6: t = (a < b);
          default: t = (a >= b);
        endcase
      end
      7'b0110011: begin
        if (ins[25]) begin
          case (f3)
            3'd0, 3'd1: prod = sa * sb;
            3'd2: prod = sa * ub;
            default: prod = {32'b0, a} * ub;
          endcase
          res = (f3 == 3'd0) ? prod[31:0] : prod[63:32];
        end else begin
          res = intOp(f3, ins[30], a, b);
        end
      end
      default: res = intOp(f3, ins[30] && f3 == 3'd5, a, immI);  // OP-IMM
    endcase
    return {res, t};
  endfunction

  // kinds 0-1 OP, 2 multiply, 3-4 OP-IMM, 5 LUI, 6 load/store, 7 branch
  function automatic logic [31:0] makeInstr(logic [2:0] kind);
    logic [31:0] w;
    logic [2:0]  f3;
    logic [6:0]  f7;
    w  = $random(seed);
    f3 = w[14:12];
    case (kind)
      3'd0, 3'd1: begin
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && w[30]) ? 7'b0100000 : 7'b0000000;
        return {f7, w[24:12], w[11:7], 7'b0110011};
      end
      3'd2: return {7'b0000001, w[24:15], 1'b0, w[13:7], 7'b0110011};
      3'd3, 3'd4: begin
        if (f3 == 3'd1) return {7'b0, w[24:7], 7'b0010011};
        else if (f3 == 3'd5) return {1'b0, w[30], 5'b0, w[24:7], 7'b0010011};
        else return {w[31:7], 7'b0010011};
      end
      3'd5: return {w[31:7], 7'b0110111};
      3'd6: begin
        if (w[0]) return {w[31:20], w[19:15], 3'b010, w[11:7], 7'b0000011};
        else return {w[31:15], 3'b010, w[11:7], 7'b0100011};
      end
      default: begin
        if (f3[2:1] == 2'b01) f3[1] = 1'b0;  // no branch on 010/011
        return {w[31:15], f3, w[11:7], 7'b1100011};
      end
    endcase
  endfunction

  task automatic sampleOutputs();
    logic [32:0] exp;
    logic        found;
    if (resValid) begin
      if (expQ.size() == 0) begin
        $display("A result came out with no pending request");
        errors++;
      end else if (lossy) begin
        found = 1'b0;
        while (!found && expQ.size() > 0) begin
          exp   = expQ.pop_front();
          found = (exp == {result, brTaken});
        end
        if (!found) begin
          $display("ERROR result %h matches no pending request after the queue overflowed",
                   result);
          errors++;
        end
      end else begin
        exp = expQ.pop_front();
        compare("result", result, exp[32:1]);
        compare("brTaken", {31'b0, brTaken}, {31'b0, exp[0]});
      end
    end
  endtask

  // check outputs on a falling edge and then drive the next inputs
  task automatic tick(logic strobe, logic [31:0] ins, logic [31:0] a, logic [31:0] b);
    @(negedge clk);
    sampleOutputs();
    instrValid = strobe;
    instr      = ins;
    rs1Val     = a;
    rs2Val     = b;
    if (strobe) begin
      expQ.push_back(modelExec(ins, a, b));
      issued++;
    end
  endtask

  initial begin
    repeat (watchLimit) @(posedge clk);
    $display("Watchdog expired before the tests completed");
    $display("Finished with errors");
    $finish;
  end

  initial begin
    arstN      = 1'b0;
    instrValid = 1'b0;
    instr      = '0;
    rs1Val     = '0;
    rs2Val     = '0;
    errors     = 0;
    issued     = 0;
    lossy      = 1'b0;
    repeat (8) begin
      @(negedge clk);
      compare("resValid", {31'b0, resValid}, 32'h0);
      compare("overflow", {31'b0, overflow}, 32'h0);
    end
    arstN = 1'b1;
    while (issued < randCount) begin
      r   = $random(seed);
      opA = $random(seed);
      opB = $random(seed);
      if (r[13:12] == 2'b00) opB = opA;  // equal operands for beq/bge
      if (r[7:0] < 8'd77 && expQ.size() < 4) tick(1'b1, makeInstr(r[10:8]), opA, opB);
      else tick(1'b0, '0, '0, '0);
    end
    while (expQ.size() > 0) tick(1'b0, '0, '0, '0);
    compare("overflow", {31'b0, overflow}, 32'h0);
    lossy = 1'b1;
    repeat (mulCount) begin
      opA = $random(seed);
      opB = $random(seed);
      tick(1'b1, makeInstr(3'd2), opA, opB);
    end
    idle = 0;
    while (idle < 8) begin
      tick(1'b0, '0, '0, '0);
      idle = resValid ? 0 : idle + 1;
    end
    compare("overflow", {31'b0, overflow}, 32'h1);
    $display("%0d instructions issued, %0d errors", issued, errors);
    if (errors == 0) $display("Finished with no errors");
    else $display("Finished with errors");
    $finish;
  end

endmodule

/* bench/execUnit_asserts.sv */
`timescale 1ns/1ns

module execUnit_asserts (
  input logic clk,
  input logic arstN,
  input logic instrValid,
  input logic resValid,
  input logic overflow
);

  int pending;  // requests not yet answered including drops

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pending <= 0;
    end else begin
      pending <= pending + (instrValid ? 1 : 0) - (resValid ? 1 : 0);
    end
  end

  // outputs held low while reset is applied
  resetQuiet: assert property (@(posedge clk) !arstN |-> !resValid && !overflow)
    else $error("resValid or overflow high during reset");

  overflowSticky: assert property (@(posedge clk) disable iff (!arstN) overflow |=> overflow)
    else $error("overflow fell without a reset");

  // a result needs an earlier request at the ports
  resultHasRequest: assert property (@(posedge clk) disable iff (!arstN)
    resValid |-> pending > 0)
    else $error("resValid without an outstanding request");

endmodule

bind execUnit execUnit_asserts u_asserts (
  .clk(clk), .arstN(arstN), .instrValid(instrValid), .resValid(resValid),
  .overflow(overflow)
);

/* source/execUnit.sv */
`timescale 1ns/1ns

module execUnit #(
  parameter int queueDepth = 4
) (
  input  logic                    clk,
  input  logic                    arstN,
  input  logic                    instrValid,
  input  logic [31:0]             instr,
  input  logic [aluPkg::xlen-1:0] rs1Val,
  input  logic [aluPkg::xlen-1:0] rs2Val,
  output logic                    resValid,
  output logic [aluPkg::xlen-1:0] result,
  output logic                    brTaken,
  output logic                    overflow
);

  logic pop;

  execBus decBus ();  // decode to queue
  execBus headBus ();  // queue head to execute

  opDecode u_opDecode (
    .clk        (clk),
    .arstN      (arstN),
    .instrValid (instrValid),
    .instr      (instr),
    .rs1Val     (rs1Val),
    .rs2Val     (rs2Val),
    .req        (decBus.source)
  );

  issueQueue #(
    .queueDepth (queueDepth),
    .payload_t  (aluPkg::execReq_t)
  ) u_issueQueue (
    .clk      (clk),
    .arstN    (arstN),
    .push     (decBus.sink),
    .head     (headBus.source),
    .pop      (pop),
    .overflow (overflow)
  );

  aluExecute u_aluExecute (
    .clk      (clk),
    .arstN    (arstN),
    .head     (headBus.sink),
    .pop      (pop),
    .resValid (resValid),
    .result   (result),
    .brTaken  (brTaken)
  );

endmodule

/* source/aluExecute.sv */
`timescale 1ns/1ns

module aluExecute (
  input  logic                    clk,
  input  logic                    arstN,
  execBus.sink                    head,
  output logic                    pop,
  output logic                    resValid,
  output logic [aluPkg::xlen-1:0] result,
  output logic                    brTaken
);

  logic [aluPkg::xlen-1:0] a;
  logic [aluPkg::xlen-1:0] b;
  logic [aluPkg::xlen-1:0] aluRes;
  logic                    taken;
  logic                    isMul;
  logic                    busy;       // second multiply cycle
  logic                    mulHigh;
  logic                    signA;
  logic                    signB;
  logic signed [65:0]      product;
  logic [63:0]             mulProd;

  assign a = head.opA;
  assign b = head.opB;

  assign isMul = (head.aluCtl[5:2] == 4'b0100);  // mul..mulhu
  assign pop   = head.valid && !busy;

  // sign extension to 33 bits covers all four multiply flavours
  assign signA   = (head.aluCtl != aluPkg::ctlMulhu);
  assign signB   = (head.aluCtl == aluPkg::ctlMul) || (head.aluCtl == aluPkg::ctlMulh);
  assign product = $signed({signA & a[31], a}) * $signed({signB & b[31], b});

  always_comb begin
    aluRes = '0;
    taken  = 1'b0;
    case (head.aluCtl)
      aluPkg::ctlAnd:  aluRes = a & b;
      aluPkg::ctlOr:   aluRes = a | b;
      aluPkg::ctlXor:  aluRes = a ^ b;
      aluPkg::ctlAdd:  aluRes = a + b;
      aluPkg::ctlSub:  aluRes = a - b;
      aluPkg::ctlSll:  aluRes = a << b[4:0];
      aluPkg::ctlSrl:  aluRes = a >> b[4:0];
      aluPkg::ctlSra:  aluRes = $signed(a) >>> b[4:0];
      aluPkg::ctlSlt:  aluRes = {31'b0, $signed(a) < $signed(b)};
      aluPkg::ctlSltu: aluRes = {31'b0, a < b};
      aluPkg::ctlBeq:  taken = (a == b);
      aluPkg::ctlBne:  taken = (a != b);
      aluPkg::ctlBlt:  taken = ($signed(a) < $signed(b));
      aluPkg::ctlBge:  taken = ($signed(a) >= $signed(b));
      aluPkg::ctlBltu: taken = (a < b);
      aluPkg::ctlBgeu: taken = (a >= b);
      default:         aluRes = '0;  // div/rem and multiplies
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      resValid <= 1'b0;
      busy     <= 1'b0;
    end else begin
      resValid <= (pop && !isMul) || busy;
      busy     <= pop && isMul;
    end
  end

  always_ff @(posedge clk) begin
    if (busy) begin
      result  <= mulHigh ? mulProd[63:32] : mulProd[31:0];
      brTaken <= 1'b0;
    end else if (pop) begin
      result  <= aluRes;
      brTaken <= head.isBranch && taken;
      if (isMul) begin
        mulProd <= product[63:0];  // first multiply cycle
        mulHigh <= (head.aluCtl != aluPkg::ctlMul);
      end
    end
  end

endmodule

/* source/issueQueue.sv */
`timescale 1ns/1ns

module issueQueue #(
  parameter int  queueDepth = 4,
  parameter type payload_t  = aluPkg::execReq_t
) (
  input  logic   clk,
  input  logic   arstN,
  execBus.sink   push,
  execBus.source head,
  input  logic   pop,
  output logic   overflow
);

  localparam int ptrW = $clog2(queueDepth);

  payload_t        mem [queueDepth];
  payload_t        wrData;
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [ptrW:0]   count;
  logic            full;
  logic            doPush;
  logic            doPop;

  // payload packs in bus field order
  assign wrData = payload_t'({push.aluCtl, push.opA, push.opB, push.isBranch});
  assign {head.aluCtl, head.opA, head.opB, head.isBranch} = mem[rdPtr];
  assign head.valid = (count != '0);

  assign full   = (count == queueDepth[ptrW:0]);
  assign doPop  = pop && head.valid;
  assign doPush = push.valid && (!full || doPop);  // a pop frees the slot

  always_ff @(posedge clk) begin
    if (doPush) mem[wrPtr] <= wrData;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (doPush) wrPtr <= wrPtr + 1'b1;  // wraps at power-of-two depth
      if (doPop) rdPtr <= rdPtr + 1'b1;
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (push.valid && !doPush) overflow <= 1'b1;  // sticky until reset
    end
  end

endmodule

/* source/opDecode.sv */
`timescale 1ns/1ns

module opDecode (
  input  logic                    clk,
  input  logic                    arstN,
  input  logic                    instrValid,
  input  logic [31:0]             instr,
  input  logic [aluPkg::xlen-1:0] rs1Val,
  input  logic [aluPkg::xlen-1:0] rs2Val,
  execBus.source                  req
);

  localparam logic [6:0] opcLoad   = 7'b0000011;
  localparam logic [6:0] opcStore  = 7'b0100011;
  localparam logic [6:0] opcBranch = 7'b1100011;
  localparam logic [6:0] opcOp     = 7'b0110011;
  localparam logic [6:0] opcOpImm  = 7'b0010011;
  localparam logic [6:0] opcLui    = 7'b0110111;

  logic [6:0]              opcode;
  logic [2:0]              func3;
  logic [6:0]              func7;
  logic [6:0]              ctlFunc7;
  aluPkg::aluOp_e          aluOp;
  aluPkg::aluCtl_e         ctl;
  logic [aluPkg::xlen-1:0] immI;
  logic [aluPkg::xlen-1:0] immS;
  logic [aluPkg::xlen-1:0] immU;
  logic [aluPkg::xlen-1:0] imm;
  logic [aluPkg::xlen-1:0] opA;
  logic [aluPkg::xlen-1:0] opB;

  assign opcode = instr[6:0];
  assign func3  = instr[14:12];
  assign func7  = instr[31:25];

  assign immI = {{20{instr[31]}}, instr[31:20]};
  assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign immU = {instr[31:12], 12'b0};

  always_comb begin
    case (opcode)
      opcLoad, opcStore: aluOp = aluPkg::memAddr;
      opcBranch:         aluOp = aluPkg::branch;
      opcOp:             aluOp = aluPkg::regReg;
      opcOpImm:          aluOp = aluPkg::regImm;
      opcLui:            aluOp = aluPkg::upperImm;
      default:           aluOp = aluPkg::memAddr;  // plain add
    endcase
  end

  assign imm = (opcode == opcStore) ? immS :
               (opcode == opcLui)   ? immU : immI;

  assign opA = (opcode == opcLui) ? '0 : rs1Val;
  assign opB = (opcode == opcOp || opcode == opcBranch) ? rs2Val : imm;

  // immediate bits overlap funct7 except on srli/srai
  assign ctlFunc7 = (opcode == opcOpImm && func3 != 3'b101) ? 7'b0 : func7;

  aluControl u_aluControl (
    .aluOp  (aluOp),
    .func3  (func3),
    .func7  (ctlFunc7),
    .result (ctl)
  );

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      req.valid <= 1'b0;
    end else begin
      req.valid <= instrValid;
    end
  end

  always_ff @(posedge clk) begin
    if (instrValid) begin
      req.aluCtl   <= ctl;
      req.opA      <= opA;
      req.opB      <= opB;
      req.isBranch <= (aluOp == aluPkg::branch);
    end
  end

endmodule

/* source/aluControl.sv */
`timescale 1ns/1ns

module aluControl (
  input  aluPkg::aluOp_e  aluOp,
  input  logic [2:0]      func3,
  input  logic [6:0]      func7,
  output aluPkg::aluCtl_e result
);

  always_comb begin
    result = aluPkg::ctlAdd;
    case (aluOp)
      aluPkg::memAddr:  result = aluPkg::ctlAdd;  // address generation
      aluPkg::upperImm: result = aluPkg::ctlAdd;  // lui, opA is zero
      aluPkg::branch: begin
        case (func3)
          3'b000:  result = aluPkg::ctlBeq;
          3'b001:  result = aluPkg::ctlBne;
          3'b100:  result = aluPkg::ctlBlt;
          3'b101:  result = aluPkg::ctlBge;
          3'b110:  result = aluPkg::ctlBltu;
          3'b111:  result = aluPkg::ctlBgeu;
          default: result = aluPkg::ctlAdd;
        endcase
      end
      aluPkg::regReg: begin
        if (func7[0]) begin  // M extension
          case (func3)
            3'b000:  result = aluPkg::ctlMul;
            3'b001:  result = aluPkg::ctlMulh;
            3'b010:  result = aluPkg::ctlMulhsu;
            3'b011:  result = aluPkg::ctlMulhu;
            3'b100:  result = aluPkg::ctlDiv;
            3'b101:  result = aluPkg::ctlDivu;
            3'b110:  result = aluPkg::ctlRem;
            default: result = aluPkg::ctlRemu;
          endcase
        end else begin
          case (func3)
            3'b000:  result = func7[5] ? aluPkg::ctlSub : aluPkg::ctlAdd;
            3'b001:  result = aluPkg::ctlSll;
            3'b010:  result = aluPkg::ctlSlt;
            3'b011:  result = aluPkg::ctlSltu;
            3'b100:  result = aluPkg::ctlXor;
            3'b101:  result = func7[5] ? aluPkg::ctlSra : aluPkg::ctlSrl;
            3'b110:  result = aluPkg::ctlOr;
            default: result = aluPkg::ctlAnd;
          endcase
        end
      end
      aluPkg::regImm: begin
        case (func3)
          3'b000:  result = aluPkg::ctlAdd;  // no subi
          3'b001:  result = aluPkg::ctlSll;
          3'b010:  result = aluPkg::ctlSlt;
          3'b011:  result = aluPkg::ctlSltu;
          3'b100:  result = aluPkg::ctlXor;
          3'b101:  result = func7[5] ? aluPkg::ctlSra : aluPkg::ctlSrl;
          3'b110:  result = aluPkg::ctlOr;
          default: result = aluPkg::ctlAnd;
        endcase
      end
      default: result = aluPkg::ctlAdd;
    endcase
  end

endmodule

/* source/execBus.sv */
`timescale 1ns/1ns

interface execBus;
  logic                       valid;     // strobe, or non-empty at the queue head
  logic [aluPkg::ctlW-1:0]    aluCtl;
  logic [aluPkg::xlen-1:0]    opA;
  logic [aluPkg::xlen-1:0]    opB;
  logic                       isBranch;

  modport source (
    output valid, aluCtl, opA, opB, isBranch
  );

  modport sink (
    input valid, aluCtl, opA, opB, isBranch
  );

endinterface

/* source/aluPkg.sv */
package aluPkg;

  localparam int xlen = 32;  // data path width
  localparam int ctlW = 6;   // ALU control code width

  // coarse class produced by decode
  typedef enum logic [2:0] {
    memAddr  = 3'b000,
    branch   = 3'b001,
    regReg   = 3'b010,
    upperImm = 3'b011,
    regImm   = 3'b110
  } aluOp_e;

  typedef enum logic [ctlW-1:0] {
    ctlAnd    = 6'b000000,
    ctlOr     = 6'b000001,
    ctlAdd    = 6'b000010,
    ctlSll    = 6'b000011,
    ctlSrl    = 6'b000100,
    ctlXor    = 6'b000101,
    ctlSub    = 6'b000110,
    ctlSra    = 6'b000111,
    ctlBeq    = 6'b001000,
    ctlBne    = 6'b001001,
    ctlBlt    = 6'b001010,
    ctlBge    = 6'b001011,
    ctlBltu   = 6'b001100,
    ctlBgeu   = 6'b001101,
    ctlMul    = 6'b010000,
    ctlMulh   = 6'b010001,
    ctlMulhsu = 6'b010010,
    ctlMulhu  = 6'b010011,
    ctlDiv    = 6'b010100,
    ctlDivu   = 6'b010101,
    ctlRem    = 6'b010110,
    ctlRemu   = 6'b010111,
    ctlSlt    = 6'b100101,
    ctlSltu   = 6'b100110
  } aluCtl_e;

  // queue entry, 71 bits
  typedef struct packed {
    logic [ctlW-1:0] aluCtl;
    logic [xlen-1:0] opA;
    logic [xlen-1:0] opB;
    logic            isBranch;
  } execReq_t;

endpackage
